//--- Makefile
SIM  := obj_dir/Vtb_write_buffer
SRCS := $(filter-out +%,$(shell cat flist.f))

.PHONY: all run clean

all: run

$(SIM): flist.f $(SRCS) include/wbuf_consts.svh
	verilator --binary --timing --assert --top-module tb_write_buffer -f flist.f

run: $(SIM)
	-./$(SIM) > sim.log 2>&1
	cat sim.log
	grep -qF '*** TEST PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

//--- flist.f
+incdir+include
logic/wbuf_pkg.sv
logic/mem_pkg.sv
logic/wbuf_store.sv
logic/dirty_issue.sv
logic/tx_slots.sv
logic/write_buffer.sv
tests/tb_write_buffer.sv

//--- include/wbuf_consts.svh
// write buffer constants
// widths, buffer depth, transaction slots and the NC I/O window

`ifndef WBUF_CONSTS_SVH
`define WBUF_CONSTS_SVH

// physical address and data word
`define WBUF_PADDR_W  32
`define WBUF_DATA_W   64
`define WBUF_BYTES    8

// byte offset inside a word, and the word tag above it
`define WBUF_OFF_W    3
`define WBUF_TAG_W    (`WBUF_PADDR_W - `WBUF_OFF_W)

// buffer entries and entry pointer width
`define WBUF_DEPTH    8
`define WBUF_PTR_W    3

// in-flight transaction slots and ID width
`define WBUF_MAX_TX   4
`define WBUF_ID_W     2

// half-open window [base, limit) treated as non-cacheable I/O space
`define WBUF_NC_BASE  32'h4000_0000
`define WBUF_NC_LIMIT 32'h5000_0000

`endif

//--- logic/dirty_issue.sv
// dirty word picker
// round-robin choice of a sendable entry, then the aligned size,
// offset, byte mask and replicated data of its next transaction

`timescale 1ns/1ps
`default_nettype none

`include "wbuf_consts.svh"

module dirty_issue (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  wbuf_pkg::wbuf_entry_t [`WBUF_DEPTH-1:0] entries_i,
  input  logic                                      nc_pending_i,
  input  logic                                      slot_free_i,
  input  wbuf_pkg::tx_id_t                          tx_id_i,
  input  logic                                      mem_ack_i,
  output mem_pkg::mem_req_t                         mem_req_o,
  output wbuf_pkg::send_upd_t                       send_o
);

  wbuf_pkg::byte_mask_t [`WBUF_DEPTH-1:0] sendable;
  logic [`WBUF_DEPTH-1:0]  has_dirty;
  wbuf_pkg::entry_ptr_t    rr_ptr_q, lock_ptr_q, pick, sel;
  logic                    lock_q, fire;
  wbuf_pkg::byte_mask_t    sel_mask, shifted, size_mask;
  logic [`WBUF_OFF_W-1:0]  off;
  logic [1:0]              size;
  logic [`WBUF_DATA_W-1:0] chosen, lane;
  wbuf_pkg::wbuf_addr_u    tx_addr;

  // words with bytes in flight wait, two TX to one word may reorder
  for (genvar k = 0; k < `WBUF_DEPTH; k++) begin : gen_sendable
    assign sendable[k]  = (|entries_i[k].txblock) ? '0 : entries_i[k].dirty;
    assign has_dirty[k] = |sendable[k];
  end

  //////////////////////////////////////////////////
  // round-robin pick
  //////////////////////////////////////////////////

  // first sendable entry at or after the pointer
  always_comb begin : p_rr
    wbuf_pkg::entry_ptr_t idx;
    pick = rr_ptr_q;
    for (int i = `WBUF_DEPTH-1; i >= 0; i--) begin
      idx = rr_ptr_q + wbuf_pkg::entry_ptr_t'(i);
      if (has_dirty[idx]) begin
        pick = idx;
      end
    end
  end

  // hold the choice while a request waits for its ack
  assign sel      = lock_q ? lock_ptr_q : pick;
  assign sel_mask = sendable[sel];

  //////////////////////////////////////////////////
  // size, mask and data lane
  //////////////////////////////////////////////////

  always_comb begin : p_offset
    off = '0;
    for (int b = `WBUF_BYTES-1; b >= 0; b--) begin
      if (sel_mask[b]) begin
        off = b[`WBUF_OFF_W-1:0];
      end
    end
  end

  assign shifted = sel_mask >> off;

  // largest aligned chunk starting at the lowest dirty byte
  always_comb begin : p_size
    if (sel_mask == 8'hff) begin
      size = 2'd3;
    end else if ((off[1:0] == 2'b00) && (shifted[3:0] == 4'hf)) begin
      size = 2'd2;
    end else if (!off[0] && (shifted[1:0] == 2'b11)) begin
      size = 2'd1;
    end else begin
      size = 2'd0;
    end
  end

  always_comb begin : p_lane
    chosen = entries_i[sel].data >> {off, 3'b000};
    case (size)
      2'd0:    size_mask = 8'h01;
      2'd1:    size_mask = 8'h03;
      2'd2:    size_mask = 8'h0f;
      default: size_mask = 8'hff;
    endcase
    // short writes replicated over all lanes
    case (size)
      2'd0:    lane = {8{chosen[7:0]}};
      2'd1:    lane = {4{chosen[15:0]}};
      2'd2:    lane = {2{chosen[31:0]}};
      default: lane = entries_i[sel].data;
    endcase
  end

  always_comb begin : p_addr
    tx_addr.f.tag = entries_i[sel].tag;
    tx_addr.f.off = off;
  end

  //////////////////////////////////////////////////
  // outputs and state
  //////////////////////////////////////////////////

  assign mem_req_o.req  = (|has_dirty) & slot_free_i;
  assign mem_req_o.addr = tx_addr.raw;
  assign mem_req_o.data = lane;
  assign mem_req_o.size = size;
  assign mem_req_o.nc   = nc_pending_i;
  assign mem_req_o.id   = tx_id_i;

  assign fire        = mem_req_o.req & mem_ack_i;
  assign send_o.fire = fire;
  assign send_o.ptr  = sel;
  assign send_o.mask = size_mask << off;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      rr_ptr_q   <= '0;
      lock_q     <= 1'b0;
      lock_ptr_q <= '0;
    end else begin
      lock_q     <= mem_req_o.req & ~mem_ack_i;
      lock_ptr_q <= sel;
      // next search starts past the served entry
      if (fire) begin
        rr_ptr_q <= sel + 1'b1;
      end
    end
  end

  // outgoing address aligned to the transfer size
  tx_aligned: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    mem_req_o.req |-> ((mem_req_o.addr[2:0] & ~(3'b111 << mem_req_o.size)) == 3'b000))
    else $error("misaligned write transaction");

endmodule

`default_nettype wire

//--- logic/mem_pkg.sv
// core and memory port types
// store request from the core, write transaction to memory and
// the acknowledge returned per transaction ID

`default_nettype none

`include "wbuf_consts.svh"

package mem_pkg;

  // store port of the core, grant comes back in the same cycle
  typedef struct packed {
    logic                    req;
    logic [`WBUF_PADDR_W-1:0] addr;
    logic [`WBUF_DATA_W-1:0]  data;
    logic [`WBUF_BYTES-1:0]   be;
  } core_wreq_t;

  // aligned write transaction
  // size: 0 byte, 1 half, 2 word, 3 dword
  typedef struct packed {
    logic                    req;
    logic [`WBUF_PADDR_W-1:0] addr;
    logic [`WBUF_DATA_W-1:0]  data;
    logic [1:0]              size;
    logic                    nc;
    wbuf_pkg::tx_id_t        id;
  } mem_req_t;

  // one-cycle completion pulse
  typedef struct packed {
    logic             vld;
    wbuf_pkg::tx_id_t id;
  } mem_rtrn_t;

endpackage

`default_nettype wire

//--- logic/tx_slots.sv
// transaction slot tracker
// one slot per ID holds the entry and bytes in flight, returns
// queue up and retire one per cycle

`timescale 1ns/1ps
`default_nettype none

`include "wbuf_consts.svh"

module tx_slots (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  wbuf_pkg::send_upd_t   send_i,
  input  mem_pkg::mem_rtrn_t    mem_rtrn_i,
  output logic                  slot_free_o,
  output wbuf_pkg::tx_id_t      tx_id_o,
  output wbuf_pkg::retire_upd_t retire_o
);

  logic [`WBUF_MAX_TX-1:0]                    slot_vld_q;
  wbuf_pkg::entry_ptr_t [`WBUF_MAX_TX-1:0] slot_ptr_q;
  wbuf_pkg::byte_mask_t [`WBUF_MAX_TX-1:0] slot_mask_q;
  wbuf_pkg::tx_id_t [`WBUF_MAX_TX-1:0]     fifo_q;
  wbuf_pkg::tx_id_t                        rd_ptr_q, wr_ptr_q, head_id;
  logic [`WBUF_ID_W:0]                     count_q;
  logic                                    fifo_empty, pop;

  //////////////////////////////////////////////////
  // free ID
  //////////////////////////////////////////////////

  always_comb begin : p_free
    tx_id_o = '0;
    for (int i = `WBUF_MAX_TX-1; i >= 0; i--) begin
      if (!slot_vld_q[i]) begin
        tx_id_o = wbuf_pkg::tx_id_t'(i);
      end
    end
  end

  assign slot_free_o = ~(&slot_vld_q);

  //////////////////////////////////////////////////
  // return queue
  //////////////////////////////////////////////////

  // registered head, a return retires one cycle after its push at the earliest
  assign fifo_empty = (count_q == '0);
  assign pop        = ~fifo_empty;
  assign head_id    = fifo_q[rd_ptr_q];

  assign retire_o.vld  = pop;
  assign retire_o.ptr  = slot_ptr_q[head_id];
  assign retire_o.mask = slot_mask_q[head_id];

  // at most one return per slot is ever queued, so no overflow
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_fifo_ctl
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (mem_rtrn_i.vld) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_q + {{`WBUF_ID_W{1'b0}}, mem_rtrn_i.vld}
                         - {{`WBUF_ID_W{1'b0}}, pop};
    end
  end

  always_ff @(posedge clk_i) begin : p_fifo_mem
    if (mem_rtrn_i.vld) begin
      fifo_q[wr_ptr_q] <= mem_rtrn_i.id;
    end
  end

  //////////////////////////////////////////////////
  // slot table
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_slot_vld
    if (!rst_ni) begin
      slot_vld_q <= '0;
    end else begin
      if (pop) begin
        slot_vld_q[head_id] <= 1'b0;
      end
      if (send_i.fire) begin
        slot_vld_q[tx_id_o] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin : p_slot_data
    if (send_i.fire) begin
      slot_ptr_q[tx_id_o]  <= send_i.ptr;
      slot_mask_q[tx_id_o] <= send_i.mask;
    end
  end

  // memory must only answer IDs that were issued
  rtrn_known: assert property (
    @(posedge clk_i) disable iff (!rst_ni) mem_rtrn_i.vld |-> slot_vld_q[mem_rtrn_i.id])
    else $error("return for an idle transaction slot");

  // a send lands on an idle slot, never on one still in flight or retiring
  no_reuse: assert property (
    @(posedge clk_i) disable iff (!rst_ni) send_i.fire |-> !slot_vld_q[tx_id_o])
    else $error("slot allocated while it is still in use");

endmodule

`default_nettype wire

//--- logic/wbuf_pkg.sv
// write buffer types
// entry record, byte masks, pointers, address view and the
// byte-state update commands passed between the buffer blocks

`default_nettype none

`include "wbuf_consts.svh"

package wbuf_pkg;

  // one bit per byte lane of a word
  typedef logic [`WBUF_BYTES-1:0] byte_mask_t;
  typedef logic [`WBUF_PTR_W-1:0] entry_ptr_t;
  typedef logic [`WBUF_ID_W-1:0]  tx_id_t;
  typedef logic [`WBUF_TAG_W-1:0] word_tag_t;

  typedef struct packed {
    word_tag_t               tag;
    logic [`WBUF_OFF_W-1:0] off;
  } addr_fields_t;

  // one address word, seen raw or split into tag and byte offset
  typedef union packed {
    logic [`WBUF_PADDR_W-1:0] raw;
    addr_fields_t             f;
  } wbuf_addr_u;

  // per byte: valid / dirty / in flight
  typedef struct packed {
    byte_mask_t              valid;
    byte_mask_t              dirty;
    byte_mask_t              txblock;
    word_tag_t               tag;
    logic [`WBUF_DATA_W-1:0] data;
  } wbuf_entry_t;

  // bytes handed to the memory side
  typedef struct packed {
    logic       fire;
    entry_ptr_t ptr;
    byte_mask_t mask;
  } send_upd_t;

  // bytes acknowledged by the memory side
  typedef struct packed {
    logic       vld;
    entry_ptr_t ptr;
    byte_mask_t mask;
  } retire_upd_t;

endpackage

`default_nettype wire

//--- logic/wbuf_store.sv
// write buffer entry store
// coalesces core byte writes into buffered words, applies NC gating
// and merges send marks and retire clears into the byte states

`timescale 1ns/1ps
`default_nettype none

`include "wbuf_consts.svh"

module wbuf_store (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic                                      cache_en_i,
  input  mem_pkg::core_wreq_t                       core_wreq_i,
  input  wbuf_pkg::send_upd_t                       send_i,
  input  wbuf_pkg::retire_upd_t                     retire_i,
  output logic                                      core_gnt_o,
  output wbuf_pkg::wbuf_entry_t [`WBUF_DEPTH-1:0] entries_o,
  output logic                                      nc_pending_o,
  output logic                                      empty_o
);

  wbuf_pkg::wbuf_entry_t [`WBUF_DEPTH-1:0] entries_d, entries_q;
  logic [`WBUF_DEPTH-1:0] used, hit_oh;
  wbuf_pkg::entry_ptr_t   hit_ptr, free_ptr, wr_ptr;
  wbuf_pkg::wbuf_addr_u   core_addr;
  logic                   full, room, addr_is_nc;
  logic                   nc_pending_d, nc_pending_q;

  //////////////////////////////////////////////////
  // lookup
  //////////////////////////////////////////////////

  assign core_addr.raw = core_wreq_i.addr;

  // an entry is in use while any byte is valid
  for (genvar k = 0; k < `WBUF_DEPTH; k++) begin : gen_flags
    assign used[k]   = |entries_q[k].valid;
    assign hit_oh[k] = used[k] && (entries_q[k].tag == core_addr.f.tag);
  end

  // lowest hit and lowest free entry
  always_comb begin : p_lookup
    hit_ptr  = '0;
    free_ptr = '0;
    for (int k = `WBUF_DEPTH-1; k >= 0; k--) begin
      if (hit_oh[k]) begin
        hit_ptr = wbuf_pkg::entry_ptr_t'(k);
      end
      if (!used[k]) begin
        free_ptr = wbuf_pkg::entry_ptr_t'(k);
      end
    end
  end

  assign full    = &used;
  assign empty_o = ~(|used);
  assign wr_ptr  = (|hit_oh) ? hit_ptr : free_ptr;
  assign room    = (|hit_oh) | ~full;

  // I/O window, or everything when the cache is off
  assign addr_is_nc = ~cache_en_i |
                      ((core_wreq_i.addr >= `WBUF_NC_BASE) &&
                       (core_wreq_i.addr <  `WBUF_NC_LIMIT));

  // NC writes wait for an empty buffer and then hold it alone
  assign core_gnt_o = core_wreq_i.req & room &
                      (empty_o | ~(addr_is_nc | nc_pending_q));

  assign nc_pending_o = nc_pending_q;
  assign entries_o    = entries_q;

  //////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////

  always_comb begin : p_update
    entries_d    = entries_q;
    nc_pending_d = nc_pending_q;

    // acked bytes leave flight, clean ones are dropped
    if (retire_i.vld) begin
      entries_d[retire_i.ptr].txblock &= ~retire_i.mask;
      entries_d[retire_i.ptr].valid   &= ~(retire_i.mask & ~entries_q[retire_i.ptr].dirty);
    end

    // sent bytes move from dirty to in flight
    if (send_i.fire) begin
      entries_d[send_i.ptr].dirty   &= ~send_i.mask;
      entries_d[send_i.ptr].txblock |= send_i.mask;
    end

    // core write last, so a byte rewritten in flight stays dirty
    if (core_gnt_o) begin
      nc_pending_d              = addr_is_nc;
      entries_d[wr_ptr].tag     = core_addr.f.tag;
      entries_d[wr_ptr].valid  |= core_wreq_i.be;
      entries_d[wr_ptr].dirty  |= core_wreq_i.be;
      for (int b = 0; b < `WBUF_BYTES; b++) begin
        if (core_wreq_i.be[b]) begin
          entries_d[wr_ptr].data[b*8 +: 8] = core_wreq_i.data[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      entries_q    <= '0;
      nc_pending_q <= 1'b0;
    end else begin
      entries_q    <= entries_d;
      nc_pending_q <= nc_pending_d;
    end
  end

  //////////////////////////////////////////////////
  // assertions
  //////////////////////////////////////////////////

  // one word never sits in two entries
  hit_onehot: assert property (
    @(posedge clk_i) disable iff (!rst_ni) core_wreq_i.req |-> $onehot0(hit_oh))
    else $error("write buffer word tag hits more than one entry");

  // legal triples are 000, 110, 101 and 111
  for (genvar k = 0; k < `WBUF_DEPTH; k++) begin : gen_chk_entry
    for (genvar j = 0; j < `WBUF_BYTES; j++) begin : gen_chk_byte
      byte_state: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        entries_q[k].valid[j] == (entries_q[k].dirty[j] | entries_q[k].txblock[j]))
        else $error("illegal byte state in entry %0d byte %0d", k, j);
    end
  end

  // slot table and entries must agree on what is in flight
  retire_live: assert property (
    @(posedge clk_i) disable iff (!rst_ni) retire_i.vld |-> |entries_q[retire_i.ptr].valid)
    else $error("retire targets an entry without valid bytes");

endmodule

`default_nettype wire

//--- logic/write_buffer.sv
// coalescing write buffer top
// core store port in, aligned ID-tagged write transactions out,
// completion pulses retire the bytes in flight

`timescale 1ns/1ps
`default_nettype none

`include "wbuf_consts.svh"

module write_buffer (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                cache_en_i,
  input  mem_pkg::core_wreq_t core_wreq_i,
  output logic                core_gnt_o,
  output mem_pkg::mem_req_t   mem_req_o,
  input  logic                mem_ack_i,
  input  mem_pkg::mem_rtrn_t  mem_rtrn_i,
  output logic                empty_o
);

  wbuf_pkg::wbuf_entry_t [`WBUF_DEPTH-1:0] entries;
  wbuf_pkg::send_upd_t                     send;
  wbuf_pkg::retire_upd_t                   retire;
  wbuf_pkg::tx_id_t                        tx_id;
  logic                                    nc_pending;
  logic                                    slot_free;

  // entry array with byte states
  wbuf_store wbuf_store_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cache_en_i   (cache_en_i),
    .core_wreq_i  (core_wreq_i),
    .send_i       (send),
    .retire_i     (retire),
    .core_gnt_o   (core_gnt_o),
    .entries_o    (entries),
    .nc_pending_o (nc_pending),
    .empty_o      (empty_o)
  );

  // next transaction out of the dirty bytes
  dirty_issue dirty_issue_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .entries_i    (entries),
    .nc_pending_i (nc_pending),
    .slot_free_i  (slot_free),
    .tx_id_i      (tx_id),
    .mem_ack_i    (mem_ack_i),
    .mem_req_o    (mem_req_o),
    .send_o       (send)
  );

  // IDs in flight and their retirement
  tx_slots tx_slots_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .send_i      (send),
    .mem_rtrn_i  (mem_rtrn_i),
    .slot_free_o (slot_free),
    .tx_id_o     (tx_id),
    .retire_o    (retire)
  );

endmodule

`default_nettype wire

//--- tests/tb_write_buffer.sv
// coalescing write buffer testbench
// random and directed core writes against a memory model with random
// ack and return timing, each accepted transaction and the final image checked

`timescale 1ns/1ps
`default_nettype none

`include "wbuf_consts.svh"

module tb_write_buffer;

  localparam logic [31:0] SEED        = 32'hbb9b2f8e;
  localparam logic [31:0] CACHED_BASE = 32'h0000_1000;
  localparam int          N_CACHED    = 12;
  localparam int          N_WORDS     = 14;
  localparam int          WAIT_MAX    = 2000;

  logic                clk_i;
  logic                rst_ni;
  logic                cache_en_i;
  mem_pkg::core_wreq_t core_wreq_i;
  logic                core_gnt_o;
  mem_pkg::mem_req_t   mem_req_o;
  logic                mem_ack_i;
  mem_pkg::mem_rtrn_t  mem_rtrn_i;
  logic                empty_o;

  // reference image of granted writes, image built by the memory, dirty shadow
  logic [`WBUF_DATA_W-1:0] ref_img [N_WORDS];
  logic [`WBUF_DATA_W-1:0] mem_img [N_WORDS];
  wbuf_pkg::byte_mask_t    shadow_dirty [N_WORDS];
  logic                    ref_nc;

  // taken by the memory and not answered yet
  logic                    out_vld [`WBUF_MAX_TX];
  wbuf_pkg::word_tag_t     out_tag [`WBUF_MAX_TX];
  wbuf_pkg::tx_id_t        rtn_id_q [$];
  int                      rtn_dly_q [$];

  logic [31:0] core_rng;
  logic [31:0] mem_rng;
  logic        resp_en;
  int          tx_count;
  int          nc_tx_count;

  initial begin : clk_gen
    clk_i = 1'b0;
    forever begin
      #20 clk_i = ~clk_i;
    end
  end

  write_buffer write_buffer_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cache_en_i  (cache_en_i),
    .core_wreq_i (core_wreq_i),
    .core_gnt_o  (core_gnt_o),
    .mem_req_o   (mem_req_o),
    .mem_ack_i   (mem_ack_i),
    .mem_rtrn_i  (mem_rtrn_i),
    .empty_o     (empty_o)
  );

  //////////////////////////////////////////////////
  // reference functions
  //////////////////////////////////////////////////

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // twelve cacheable words, then two in the I/O window
  function automatic logic [31:0] word_addr(input int w);
    if (w < N_CACHED) begin
      return CACHED_BASE + 32'(w) * 32'd8;
    end else begin
      return `WBUF_NC_BASE + 32'(w - N_CACHED) * 32'd8;
    end
  endfunction

  function automatic int word_of(input wbuf_pkg::word_tag_t tag);
    int idx;
    idx = -1;
    for (int w = 0; w < N_WORDS; w++) begin
      if (wbuf_pkg::word_tag_t'(word_addr(w) >> 3) == tag) begin
        idx = w;
      end
    end
    return idx;
  endfunction

  function automatic logic is_nc(input logic [31:0] addr);
    return !cache_en_i || ((addr >= `WBUF_NC_BASE) && (addr < `WBUF_NC_LIMIT));
  endfunction

  function automatic int lowest_byte(input wbuf_pkg::byte_mask_t m);
    int o;
    o = -1;
    for (int b = `WBUF_BYTES-1; b >= 0; b--) begin
      if (m[b]) begin
        o = b;
      end
    end
    return o;
  endfunction

  // size code on top, covered bytes below
  function automatic logic [9:0] ref_chunk(input wbuf_pkg::byte_mask_t dirty, input int off);
    wbuf_pkg::byte_mask_t above;
    wbuf_pkg::byte_mask_t mask;
    int                   n;
    logic [1:0]           code;
    above = dirty >> off;
    if (off == 0 && dirty == 8'hff) begin
      n    = 8;
      code = 2'd3;
    end else if (off % 4 == 0 && above[3:0] == 4'hf) begin
      n    = 4;
      code = 2'd2;
    end else if (off % 2 == 0 && above[1:0] == 2'b11) begin
      n    = 2;
      code = 2'd1;
    end else begin
      n    = 1;
      code = 2'd0;
    end
    mask = '0;
    for (int b = 0; b < `WBUF_BYTES; b++) begin
      if (b >= off && b < off + n) begin
        mask[b] = 1'b1;
      end
    end
    return {code, mask};
  endfunction

  // later bytes overwrite earlier ones
  function automatic logic [`WBUF_DATA_W-1:0] merge_bytes(input logic [`WBUF_DATA_W-1:0] old,
                                                         input logic [`WBUF_DATA_W-1:0] data,
                                                         input wbuf_pkg::byte_mask_t be);
    logic [`WBUF_DATA_W-1:0] res;
    res = old;
    for (int b = 0; b < `WBUF_BYTES; b++) begin
      if (be[b]) begin
        res[b*8 +: 8] = data[b*8 +: 8];
      end
    end
    return res;
  endfunction

  //////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR @%0t: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  task automatic check_image(input wbuf_pkg::word_tag_t tag,
                             input logic [`WBUF_DATA_W-1:0] got,
                             input logic [`WBUF_DATA_W-1:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR @%0t: memory word %h holds %h, expected %h",
                          $time, {tag, 3'b000}, got, exp));
    end
  endtask

  task automatic check_req(input mem_pkg::mem_req_t got, input mem_pkg::mem_req_t exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR @%0t: tx addr %h data %h size %0d nc %b, expected %h %h %0d %b",
                          $time, got.addr, got.data, got.size, got.nc,
                          exp.addr, exp.data, exp.size, exp.nc));
    end
  endtask

  //////////////////////////////////////////////////
  // memory side model and checker
  //////////////////////////////////////////////////

  task automatic note_transaction();
    mem_pkg::mem_req_t    exp;
    wbuf_pkg::word_tag_t  tag;
    wbuf_pkg::byte_mask_t sent;
    logic [9:0]           chunk;
    int                   w;
    int                   off;
    int                   n;
    int                   busy;
    tag = wbuf_pkg::word_tag_t'(mem_req_o.addr >> 3);
    w   = word_of(tag);
    if (w < 0) begin
      abort_run($sformatf("ERR @%0t: transaction to unknown address %h", $time, mem_req_o.addr));
    end else if (shadow_dirty[w] == '0) begin
      abort_run($sformatf("ERR @%0t: transaction to %h without dirty bytes",
                          $time, mem_req_o.addr));
    end
    busy = 0;
    for (int i = 0; i < `WBUF_MAX_TX; i++) begin
      if (out_vld[i]) begin
        busy++;
        if (out_tag[i] == tag) begin
          abort_run($sformatf("ERR @%0t: second outstanding transaction to word %h",
                              $time, {tag, 3'b000}));
        end
      end
    end
    check_flag("ID already outstanding", out_vld[mem_req_o.id], 1'b0);
    check_flag("five transactions outstanding", busy >= `WBUF_MAX_TX, 1'b0);
    off   = lowest_byte(shadow_dirty[w]);
    chunk = ref_chunk(shadow_dirty[w], off);
    sent  = chunk[7:0];
    n     = 1 << chunk[9:8];
    exp.req  = 1'b1;
    exp.addr = {tag, 3'(off)};
    exp.size = chunk[9:8];
    exp.nc   = ref_nc;
    exp.id   = mem_req_o.id;
    // chosen bytes repeated over every lane
    for (int l = 0; l < `WBUF_BYTES; l++) begin
      exp.data[l*8 +: 8] = ref_img[w][(off + l % n)*8 +: 8];
    end
    check_req(mem_req_o, exp);
    mem_img[w]      = merge_bytes(mem_img[w], mem_req_o.data, sent);
    shadow_dirty[w] = shadow_dirty[w] & ~sent;
    out_vld[mem_req_o.id] = 1'b1;
    out_tag[mem_req_o.id] = tag;
    mem_rng = next_rand(mem_rng);
    rtn_id_q.push_back(mem_req_o.id);
    rtn_dly_q.push_back(int'(mem_rng[31:29]));
    tx_count++;
    if (ref_nc) begin
      nc_tx_count++;
    end
  endtask

  task automatic note_grant();
    int   w;
    logic nc;
    w  = word_of(wbuf_pkg::word_tag_t'(core_wreq_i.addr >> 3));
    nc = is_nc(core_wreq_i.addr);
    // NC traffic only enters an empty buffer
    if (nc || ref_nc) begin
      check_flag("empty_o at an NC gated grant", empty_o, 1'b1);
    end
    ref_img[w]      = merge_bytes(ref_img[w], core_wreq_i.data, core_wreq_i.be);
    shadow_dirty[w] = shadow_dirty[w] | core_wreq_i.be;
    ref_nc          = nc;
  endtask

  // random ack, then at most one due return per cycle
  task automatic respond();
    mem_pkg::mem_rtrn_t rtn;
    int                 pick;
    mem_rng   = next_rand(mem_rng);
    mem_ack_i <= resp_en & (mem_rng[31:30] != 2'b00);
    pick = -1;
    for (int k = 0; k < rtn_dly_q.size(); k++) begin
      if (rtn_dly_q[k] > 0) begin
        rtn_dly_q[k]--;
      end else if (pick < 0) begin
        pick = k;
      end
    end
    rtn = '0;
    if (pick >= 0) begin
      rtn.vld = 1'b1;
      rtn.id  = rtn_id_q[pick];
      rtn_id_q.delete(pick);
      rtn_dly_q.delete(pick);
    end
    mem_rtrn_i <= rtn;
  endtask

  // samples on the falling edge, drives on the rising edge
  initial begin : mem_side
    mem_ack_i  = 1'b0;
    mem_rtrn_i = '0;
    mem_rng    = ~SEED;
    ref_nc     = 1'b0;
    for (int w = 0; w < N_WORDS; w++) begin
      ref_img[w]      = '0;
      mem_img[w]      = '0;
      shadow_dirty[w] = '0;
    end
    for (int i = 0; i < `WBUF_MAX_TX; i++) begin
      out_vld[i] = 1'b0;
      out_tag[i] = '0;
    end
    forever begin
      @(negedge clk_i);
      if (rst_ni) begin
        if (mem_rtrn_i.vld) begin
          out_vld[mem_rtrn_i.id] = 1'b0;
        end
        if (mem_req_o.req && mem_ack_i) begin
          note_transaction();
        end
        if (core_wreq_i.req && core_gnt_o) begin
          note_grant();
        end
      end
      @(posedge clk_i);
      respond();
    end
  end

  //////////////////////////////////////////////////
  // core side stimulus
  //////////////////////////////////////////////////

  task automatic make_write(output mem_pkg::core_wreq_t wr);
    int word;
    core_rng = next_rand(core_rng);
    wr.req   = core_rng[31];
    // about one write in sixteen goes to the I/O window
    if (core_rng[30:27] == 4'h0) begin
      word = N_CACHED + int'(core_rng[26]);
    end else begin
      word = int'(core_rng[26:23]) % N_CACHED;
    end
    wr.addr  = word_addr(word);
    core_rng = next_rand(core_rng);
    wr.be    = (core_rng[31:24] == 8'h00) ? 8'h01 : core_rng[31:24];
    core_rng = next_rand(core_rng);
    wr.data[63:32] = core_rng;
    core_rng = next_rand(core_rng);
    wr.data[31:0]  = core_rng;
  endtask

  task automatic try_write(input int w, input wbuf_pkg::byte_mask_t be,
                           input logic [`WBUF_DATA_W-1:0] data, output logic granted);
    mem_pkg::core_wreq_t wr;
    wr.req  = 1'b1;
    wr.addr = word_addr(w);
    wr.data = data;
    wr.be   = be;
    @(posedge clk_i);
    core_wreq_i <= wr;
    @(negedge clk_i);
    granted = core_gnt_o;
    @(posedge clk_i);
    core_wreq_i.req <= 1'b0;
  endtask

  task automatic set_responder(input logic en);
    @(negedge clk_i);
    resp_en = en;
  endtask

  task automatic wait_empty();
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk_i);
      cycles++;
      if (cycles > WAIT_MAX) begin
        abort_run("timed out waiting for the write buffer to drain");
      end
    end while (!empty_o);
  endtask

  task automatic compare_images();
    for (int w = 0; w < N_WORDS; w++) begin
      check_image(wbuf_pkg::word_tag_t'(word_addr(w) >> 3), mem_img[w], ref_img[w]);
      check_flag("dirty bytes left after drain", |shadow_dirty[w], 1'b0);
    end
  endtask

  initial begin : main_proc
    mem_pkg::core_wreq_t wr;
    logic                granted;
    int                  tries;
    cache_en_i  = 1'b1;
    core_wreq_i = '0;
    rst_ni      = 1'b0;
    resp_en     = 1'b0;
    core_rng    = SEED;
    tx_count    = 0;
    nc_tx_count = 0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;

    @(negedge clk_i);
    check_flag("empty_o after reset", empty_o, 1'b1);
    check_flag("miss request after reset", mem_req_o.req, 1'b0);
    check_flag("grant without a request", core_gnt_o, 1'b0);
    set_responder(1'b1);

    // random coalescing traffic, then drain
    for (int i = 0; i < 400; i++) begin
      make_write(wr);
      @(posedge clk_i);
      core_wreq_i <= wr;
    end
    @(posedge clk_i);
    core_wreq_i.req <= 1'b0;
    wait_empty();
    compare_images();

    // memory stalled, all entries taken
    set_responder(1'b0);
    for (int w = 0; w < `WBUF_DEPTH; w++) begin
      try_write(w, 8'h01, {8{8'(w + 16)}}, granted);
      check_flag("grant for a new word with a free entry", granted, 1'b1);
    end
    try_write(3, 8'hf0, 64'h0123_4567_89ab_cdef, granted);
    check_flag("grant for a hit in a full buffer", granted, 1'b1);
    try_write(9, 8'h0f, 64'hfedc_ba98_7654_3210, granted);
    check_flag("grant for a new word in a full buffer", granted, 1'b0);
    set_responder(1'b1);
    wait_empty();
    compare_images();

    // NC write waits for an empty buffer
    set_responder(1'b0);
    try_write(0, 8'h3c, 64'h1111_2222_3333_4444, granted);
    check_flag("grant for a cacheable write", granted, 1'b1);
    try_write(N_CACHED, 8'hff, 64'h5555_6666_7777_8888, granted);
    check_flag("grant for an NC write into a busy buffer", granted, 1'b0);
    set_responder(1'b1);
    wait_empty();

    // NC write holds the buffer alone
    set_responder(1'b0);
    try_write(N_CACHED, 8'hff, 64'h9999_aaaa_bbbb_cccc, granted);
    check_flag("grant for an NC write into an empty buffer", granted, 1'b1);
    try_write(1, 8'h01, 64'h0000_0000_0000_00a5, granted);
    check_flag("grant behind a pending NC write", granted, 1'b0);
    set_responder(1'b1);
    tries   = 0;
    granted = 1'b0;
    while (!granted) begin
      if (tries == WAIT_MAX) begin
        abort_run("timed out retrying a write behind an NC write");
      end
      try_write(1, 8'h01, 64'h0000_0000_0000_00a5, granted);
      tries++;
    end
    wait_empty();
    compare_images();
    check_flag("NC transaction seen", nc_tx_count > 0, 1'b1);
    check_flag("transactions seen", tx_count > 0, 1'b1);

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire
